/* tb/UProc_golden.txt */
// First data line: image words 0..7 as held in the EEPROM.
// Records: op {test, kind}, address, write data, expected value. Op 0000 ends the list.
1234 A5C3 0F0F BEAD 7E81 C0DE 3C3C 9001
// Test 1, reads issued while boot is still running.
0106 0005 0000 C0DE
0101 0002 0000 0F0F
// Test 2, image copy.
0208 0000 0000 0001
// Test 3, SRAM write protection.
0302 0003 BEEF 0001
0305 0003 0000 BEAD
0302 C000 8000 0000
0304 0000 0000 0001
0302 0003 BEEF 0000
0301 0003 0000 BEEF
0305 0003 0000 BEEF
// Test 4, CCTRL field decode.
0402 C000 001A 0000
0407 0000 0000 001A
0401 C000 0000 001A
// Test 5, pause pin and STATUS.
0503 0000 0001 0000
0504 0000 0000 0001
0501 C001 0000 0003
0503 0000 0000 0000
0504 0000 0000 0000
0501 C001 0000 0002
0000 0000 0000 0000

/* UProc.f */
+incdir+rtl
rtl/UProcPkg.sv
rtl/BootImage.sv
rtl/DebugPort.sv
rtl/MemController.sv
rtl/MappedRegisters.sv
rtl/UProc.sv
tb/UProc_properties.sv
tb/UProcTb.sv

/* Bender.yml */
package:
  name: uproc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/UProcPkg.sv
      - rtl/BootImage.sv
      - rtl/DebugPort.sv
      - rtl/MemController.sv
      - rtl/MappedRegisters.sv
      - rtl/UProc.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/UProc_properties.sv
      - tb/UProcTb.sv

/* tb/UProcTb.sv */
`default_nettype none

`include "UProc_macros.svh"

module UProcTb;

	localparam int TIMEOUT = 2000;
	localparam int GOLD_N  = 128;

	// Record kinds in the low byte of the op word.
	localparam logic [7:0] K_READ   = 8'h01;
	localparam logic [7:0] K_WRITE  = 8'h02;
	localparam logic [7:0] K_PIN    = 8'h03;
	localparam logic [7:0] K_WAITP  = 8'h04;
	localparam logic [7:0] K_SRAM   = 8'h05;
	localparam logic [7:0] K_BOOTRD = 8'h06;
	localparam logic [7:0] K_INT    = 8'h07;
	localparam logic [7:0] K_BOOT   = 8'h08;

	logic               sysClk = 1'b0;
	logic               rstN;
	UProcPkg::apbReq_t  apbReq;
	UProcPkg::apbRsp_t  apbRsp;
	logic               spiMISO, spiMOSI, spiCLK, spiCSn;
	logic               memEn, memWr;
	logic [`ADDR_W-1:0] memAddr;
	logic [`DATA_W-1:0] memWrData, memRdData;
	logic               smDoPause, smIsBooted, smIsPaused, intEn;
	logic [3:0]         intCode;

	logic [15:0]        golden [0:GOLD_N-1];
	logic [15:0]        sram [0:65535];
	logic [15:0]        sramRdQ = '0;
	logic               spiClkQ = 1'b0;
	logic [23:0]        cmdRx = '1;
	logic               bootedAtStart, bootedAtDone, timedOut;
	int                 fallCnt, riseCnt, bitIdx, curTest;
	int                 errCount, checkCount, testErr;

	// 4 time unit clock.
	always #2 sysClk = ~sysClk;

	UProc dut_i (
		.i_sysClk(sysClk), .i_rstN(rstN),
		.i_apb(apbReq), .o_apb(apbRsp),
		.i_spiMISO(spiMISO), .o_spiMOSI(spiMOSI),
		.o_spiCLK(spiCLK), .o_spiCSn(spiCSn),
		.o_memEn(memEn), .o_memWr(memWr),
		.o_memAddr(memAddr), .o_memWrData(memWrData),
		.i_memRdData(memRdData),
		.i_smDoPause(smDoPause), .o_smIsBooted(smIsBooted),
		.o_smIsPaused(smIsPaused), .o_intCode(intCode), .o_intEn(intEn)
	);

	// ---------------------------------------------------------------------
	// SRAM model with a one cycle read.
	// ---------------------------------------------------------------------
	always @(posedge sysClk) begin
		if (memEn && memWr) begin
			sram[memAddr] <= memWrData;
		end
		if (memEn && !memWr) begin
			sramRdQ <= sram[memAddr];
		end
	end

	always @(negedge sysClk) begin
		memRdData = sramRdQ;
	end

	// ---------------------------------------------------------------------
	// EEPROM model.
	// ---------------------------------------------------------------------

	// Skips opcode and address, then streams image MSB first.
	always @(negedge sysClk) begin
		if (spiCSn) begin
			fallCnt = 0;
			riseCnt = 0;
			spiMISO = 1'b0;
		end else if (spiClkQ && !spiCLK) begin
			fallCnt = fallCnt + 1;
			bitIdx  = fallCnt - 24;
			if (bitIdx >= 0 && bitIdx < `BOOT_WORDS * 16) begin
				spiMISO = golden[bitIdx / 16][15 - (bitIdx % 16)];
			end
		end else if (!spiClkQ && spiCLK) begin
			// Command bits are taken on rising SCK.
			if (riseCnt < 24) begin
				cmdRx = {cmdRx[22:0], spiMOSI};
			end
			riseCnt = riseCnt + 1;
		end
		spiClkQ = spiCLK;
	end

	function automatic string testName(input int t);
		case (t)
			0:       return "reset state";
			1:       return "read under boot back-pressure";
			2:       return "boot copy";
			3:       return "pause and write protection";
			4:       return "control register decode";
			5:       return "pause pin and status";
			default: return "unnamed";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
	                          input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			testErr++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		timedOut = 1'b1;
		errCount++;
		testErr++;
		$display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
	endtask

	task automatic finishTest(input int t);
		if (testErr == 0) begin
			$display("[PASS] %s", testName(t));
		end else begin
			$display("[FAIL] %s with %0d errors", testName(t), testErr);
		end
	endtask

	// One APB transfer held until pready.
	task automatic apbTransfer(input logic write, input logic [15:0] addr,
	                           input logic [15:0] wdata, output logic [15:0] rdData,
	                           output logic err);
		int n;
		@(negedge sysClk);
		apbReq        = '0;
		apbReq.psel   = 1'b1;
		apbReq.pwrite = write;
		apbReq.paddr  = addr;
		apbReq.pwdata = wdata;
		bootedAtStart = smIsBooted;
		@(negedge sysClk);
		apbReq.penable = 1'b1;
		n = 0;
		while (!apbRsp.pready && n < TIMEOUT) begin
			@(negedge sysClk);
			n++;
		end
		if (apbRsp.pready) begin
			rdData       = apbRsp.prdata;
			err          = apbRsp.pslverr;
			bootedAtDone = smIsBooted;
		end else begin
			rdData = 'x;
			err    = 1'bx;
			reportTimeout("APB pready");
		end
		// Completing edge passes before the bus goes idle.
		@(negedge sysClk);
		apbReq = '0;
	endtask

	task automatic waitPaused(input logic level);
		int n;
		n = 0;
		while (smIsPaused !== level && n < TIMEOUT) begin
			@(negedge sysClk);
			n++;
		end
		if (smIsPaused !== level) begin
			reportTimeout("pause state change");
		end
	endtask

	task automatic waitBooted();
		int n;
		n = 0;
		while (smIsBooted !== 1'b1 && n < TIMEOUT) begin
			@(negedge sysClk);
			n++;
		end
		if (smIsBooted !== 1'b1) begin
			reportTimeout("boot completion");
		end
	endtask

	task automatic runRecord(input logic [7:0] kind, input logic [15:0] addr,
	                         input logic [15:0] wdata, input logic [15:0] expVal);
		logic [15:0] rdData;
		logic        err;
		string       name;
		name = testName(curTest);
		case (kind)
			K_READ: begin
				apbTransfer(1'b0, addr, 16'h0000, rdData, err);
				checkValue(name, expVal, rdData);
			end
			K_WRITE: begin
				apbTransfer(1'b1, addr, wdata, rdData, err);
				checkValue(name, expVal, {15'b0, err});
			end
			K_PIN: begin
				@(negedge sysClk);
				smDoPause = wdata[0];
			end
			K_WAITP: begin
				waitPaused(expVal[0]);
				checkValue(name, expVal, {15'b0, smIsPaused});
			end
			K_SRAM: begin
				checkValue(name, expVal, sram[addr]);
			end
			K_BOOTRD: begin
				// Issued before boot, answered after it.
				apbTransfer(1'b0, addr, 16'h0000, rdData, err);
				checkValue(name, expVal, rdData);
				checkValue(name, 16'h0000, {15'b0, bootedAtStart});
				checkValue(name, 16'h0001, {15'b0, bootedAtDone});
			end
			K_INT: begin
				checkValue(name, expVal, {11'b0, intEn, intCode});
			end
			K_BOOT: begin
				waitBooted();
				checkValue(name, expVal, {15'b0, smIsBooted});
				for (int i = 0; i < `BOOT_WORDS; i++) begin
					checkValue(name, golden[i], sram[i]);
				end
				// EEPROM saw read opcode 03 and a zero start address.
				checkValue(name, 16'h0003, {8'h00, cmdRx[23:16]});
				checkValue(name, 16'h0000, cmdRx[15:0]);
				// Chip select released once booted.
				checkValue(name, 16'h0001, {15'b0, spiCSn});
			end
			default: begin
				errCount++;
				testErr++;
				$display("Unknown operation kind %h in the golden file", kind);
			end
		endcase
	endtask

	// ---------------------------------------------------------------------
	// Main sequence.
	// ---------------------------------------------------------------------
	initial begin
		int          idx;
		logic [15:0] op;
		rstN       = 1'b0;
		apbReq     = '0;
		spiMISO    = 1'b0;
		memRdData  = '0;
		smDoPause  = 1'b0;
		timedOut   = 1'b0;
		errCount   = 0;
		checkCount = 0;
		testErr    = 0;
		fallCnt    = 0;
		riseCnt    = 0;
		for (int i = 0; i < GOLD_N; i++) begin
			golden[i] = 16'h0000;
		end
		$readmemh("tb/UProc_golden.txt", golden);

		// Reset for 4 cycles.
		repeat (4) @(posedge sysClk);
		@(negedge sysClk);
		curTest = 0;
		// Pin order memEn memWr pready pslverr spiCLK booted paused intEn spiCSn intCode.
		checkValue(testName(0), 16'h0010, {3'b0, memEn, memWr, apbRsp.pready,
		           apbRsp.pslverr, spiCLK, smIsBooted, smIsPaused, intEn, spiCSn, intCode});
		finishTest(0);
		rstN = 1'b1;

		// Records follow the image words.
		idx     = `BOOT_WORDS;
		curTest = -1;
		while (!timedOut && idx + 3 < GOLD_N && golden[idx] != 16'h0000) begin
			op = golden[idx];
			if (int'(op[15:8]) != curTest) begin
				if (curTest >= 0) begin
					finishTest(curTest);
				end
				curTest = op[15:8];
				testErr = 0;
			end
			runRecord(op[7:0], golden[idx + 1], golden[idx + 2], golden[idx + 3]);
			idx += 4;
		end
		if (curTest >= 0) begin
			finishTest(curTest);
		end

		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0 && !timedOut) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/UProc_properties.sv */
`default_nettype none

module UProcProperties (
	input  logic                i_sysClk,
	input  logic                i_rstN,
	input  UProcPkg::apbReq_t   i_apb,
	input  UProcPkg::apbRsp_t   i_apbRsp,
	input  logic                i_memEn,
	input  logic                i_memWr,
	input  logic                i_smIsBooted
);

	// ---------------------------------------------------------------------
	// SRAM pins.
	// ---------------------------------------------------------------------

	// No write strobe without an enabled cycle.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		i_memWr |-> i_memEn)
		else $error("SRAM write strobe seen without memory enable");

	// ---------------------------------------------------------------------
	// APB and boot state.
	// ---------------------------------------------------------------------

	// Ready only inside an access phase.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		i_apbRsp.pready |-> (i_apb.psel && i_apb.penable))
		else $error("APB pready outside an access phase");

	// Booted flag is sticky until reset.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		i_smIsBooted |=> i_smIsBooted)
		else $error("Booted flag fell while out of reset");

endmodule

bind UProc UProcProperties props (
	.i_sysClk(i_sysClk),
	.i_rstN(i_rstN),
	.i_apb(i_apb),
	.i_apbRsp(o_apb),
	.i_memEn(o_memEn),
	.i_memWr(o_memWr),
	.i_smIsBooted(o_smIsBooted)
);

`default_nettype wire

/* rtl/UProc.sv */
`default_nettype none

`include "UProc_macros.svh"

module UProc (
	input  logic               i_sysClk,
	input  logic               i_rstN,

	// Debug host APB.
	input  UProcPkg::apbReq_t  i_apb,
	output UProcPkg::apbRsp_t  o_apb,

	// EEPROM SPI pins.
	input  logic               i_spiMISO,
	output logic               o_spiMOSI,
	output logic               o_spiCLK,
	output logic               o_spiCSn,

	// SRAM pins.
	output logic               o_memEn,
	output logic               o_memWr,
	output logic [`ADDR_W-1:0] o_memAddr,
	output logic [`DATA_W-1:0] o_memWrData,
	input  logic [`DATA_W-1:0] i_memRdData,

	// State and interrupt pins.
	input  logic               i_smDoPause,
	output logic               o_smIsBooted,
	output logic               o_smIsPaused,
	output logic [3:0]         o_intCode,
	output logic               o_intEn
);

	// Requester wires.
	UProcPkg::memReq_t  bootReq, dbgReq;
	logic               bootGrant, dbgGrant, rdValid;
	logic [`DATA_W-1:0] rdData;

	// Mapped register wires.
	logic               mapWrEn, mapRdEn;
	logic [1:0]         mapAddr;
	logic [`DATA_W-1:0] mapWrData, mapRdData;

	// -------------------------------------------------------------------
	// Bootloader copies the EEPROM image into SRAM.
	// -------------------------------------------------------------------
	BootImage BOOT_IMAGE (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_spiMISO(i_spiMISO), .o_spiMOSI(o_spiMOSI),
		.o_spiCLK(o_spiCLK), .o_spiCSn(o_spiCSn),
		.i_grant(bootGrant), .o_req(bootReq),
		.o_nowBooted(o_smIsBooted)
	);

	// Host access.
	DebugPort DEBUG_PORT (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_apb(i_apb), .o_apb(o_apb),
		.o_req(dbgReq), .i_grant(dbgGrant),
		.i_rdValid(rdValid), .i_rdData(rdData),
		.i_isPaused(o_smIsPaused)
	);

	// -------------------------------------------------------------------
	// Shared bus arbiter and decoder.
	// -------------------------------------------------------------------
	MemController MEM_CTRL (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_bootReq(bootReq), .i_dbgReq(dbgReq),
		.o_bootGrant(bootGrant), .o_dbgGrant(dbgGrant),
		.o_rdValid(rdValid), .o_rdData(rdData),
		.o_memEn(o_memEn), .o_memWr(o_memWr),
		.o_memAddr(o_memAddr), .o_memWrData(o_memWrData),
		.i_memRdData(i_memRdData),
		.o_mapWrEn(mapWrEn), .o_mapRdEn(mapRdEn),
		.o_mapAddr(mapAddr), .o_mapWrData(mapWrData),
		.i_mapRdData(mapRdData)
	);

	// Control, status and pause network.
	MappedRegisters MAPPED_REGS (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_wrEn(mapWrEn), .i_rdEn(mapRdEn),
		.i_addr(mapAddr), .i_wrData(mapWrData), .o_rdData(mapRdData),
		.i_smDoPause(i_smDoPause), .i_isBooted(o_smIsBooted),
		.o_isPaused(o_smIsPaused),
		.o_intEn(o_intEn), .o_intCode(o_intCode)
	);

endmodule

`default_nettype wire

/* rtl/MappedRegisters.sv */
`default_nettype none

`include "UProc_macros.svh"

module MappedRegisters (
	input  logic               i_sysClk,
	input  logic               i_rstN,

	// Register strobe.
	input  logic               i_wrEn,
	input  logic               i_rdEn,
	input  logic [1:0]         i_addr,
	input  logic [`DATA_W-1:0] i_wrData,
	output logic [`DATA_W-1:0] o_rdData,

	// Pause network.
	input  logic               i_smDoPause,
	input  logic               i_isBooted,
	output logic               o_isPaused,

	// Interrupt controls.
	output logic               o_intEn,
	output logic [3:0]         o_intCode
);

	// Register offsets.
	localparam logic [1:0] OFS_CCTRL  = 2'd0;
	localparam logic [1:0] OFS_STATUS = 2'd1;

	UProcPkg::cctrlWord_u cctrl;
	logic                 startPause, isPaused;

	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			cctrl      <= '0;
			startPause <= 1'b0;
			isPaused   <= 1'b0;
		end else begin
			if (i_wrEn && (i_addr == OFS_CCTRL)) begin
				cctrl.raw <= i_wrData;
			end
			// Stage one merges both pause sources.
			startPause <= cctrl.f.pause | i_smDoPause;
			// Stage two only pauses a booted core.
			isPaused   <= startPause & i_isBooted;
		end
	end

	// Read mux.
	always_comb begin
		o_rdData = '0;
		if (i_rdEn) begin
			case (i_addr)
				OFS_CCTRL:  o_rdData = cctrl.raw;
				OFS_STATUS: o_rdData[1:0] = {i_isBooted, isPaused};
				default:    o_rdData = '0;
			endcase
		end
	end

	// Field outputs.
	assign o_isPaused = isPaused;
	assign o_intEn    = cctrl.f.intEn;
	assign o_intCode  = cctrl.f.intCode;

endmodule

`default_nettype wire

/* rtl/MemController.sv */
`default_nettype none

`include "UProc_macros.svh"

module MemController (
	input  logic               i_sysClk,
	input  logic               i_rstN,

	// Requesters.
	input  UProcPkg::memReq_t  i_bootReq,
	input  UProcPkg::memReq_t  i_dbgReq,
	output logic               o_bootGrant,
	output logic               o_dbgGrant,
	output logic               o_rdValid,
	output logic [`DATA_W-1:0] o_rdData,

	// SRAM pins.
	output logic               o_memEn,
	output logic               o_memWr,
	output logic [`ADDR_W-1:0] o_memAddr,
	output logic [`DATA_W-1:0] o_memWrData,
	input  logic [`DATA_W-1:0] i_memRdData,

	// Mapped register strobe.
	output logic               o_mapWrEn,
	output logic               o_mapRdEn,
	output logic [1:0]         o_mapAddr,
	output logic [`DATA_W-1:0] o_mapWrData,
	input  logic [`DATA_W-1:0] i_mapRdData
);

	localparam int BCNT_W = $clog2(`BOOT_WORDS + 1);

	UProcPkg::memReq_t sel;
	logic              selValid, isMap, bootDone, rdPendQ;
	logic [BCNT_W-1:0] bootCnt;

	// -------------------------------------------------------------------
	// Arbitration.
	// -------------------------------------------------------------------

	// Debug locked out until every image word is stored.
	assign bootDone    = (bootCnt == BCNT_W'(`BOOT_WORDS));
	assign o_bootGrant = i_bootReq.en;
	assign o_dbgGrant  = i_dbgReq.en & ~i_bootReq.en & bootDone;
	assign selValid    = o_bootGrant | o_dbgGrant;
	assign sel         = o_bootGrant ? i_bootReq : i_dbgReq;

	// -------------------------------------------------------------------
	// Address decode.
	// -------------------------------------------------------------------

	assign isMap = (sel.addr[`ADDR_W-1 -: 2] == `MAP_PREFIX);

	// SRAM never sees the mapped region.
	assign o_memEn     = selValid & ~isMap;
	assign o_memWr     = selValid & sel.wr & ~isMap;
	assign o_memAddr   = sel.addr;
	assign o_memWrData = sel.wrData;

	// Register strobes on the low address bits.
	assign o_mapWrEn   = selValid & sel.wr & isMap;
	assign o_mapRdEn   = selValid & ~sel.wr & isMap;
	assign o_mapAddr   = sel.addr[1:0];
	assign o_mapWrData = sel.wrData;

	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			bootCnt <= '0;
			rdPendQ <= 1'b0;
		end else begin
			// Count boot writes.
			if (o_bootGrant && !bootDone) begin
				bootCnt <= bootCnt + 1'b1;
			end
			// Debug SRAM read owed next cycle.
			rdPendQ <= o_dbgGrant & ~sel.wr & ~isMap;
		end
	end

	// -------------------------------------------------------------------
	// Read return.
	// -------------------------------------------------------------------

	// Register reads come back in the grant cycle.
	assign o_rdValid = rdPendQ | o_mapRdEn;
	assign o_rdData  = o_mapRdEn ? i_mapRdData : i_memRdData;

endmodule

`default_nettype wire

/* rtl/DebugPort.sv */
`default_nettype none

`include "UProc_macros.svh"

module DebugPort (
	input  logic               i_sysClk,
	input  logic               i_rstN,

	// APB completer.
	input  UProcPkg::apbReq_t  i_apb,
	output UProcPkg::apbRsp_t  o_apb,

	// SRAM bus request.
	output UProcPkg::memReq_t  o_req,
	input  logic               i_grant,
	input  logic               i_rdValid,
	input  logic [`DATA_W-1:0] i_rdData,

	// Processor state.
	input  logic               i_isPaused
);

	// Transfer states.
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;
	localparam logic [1:0] ST_DONE = 2'd3;

	logic [1:0]         state;
	logic               reqEn, reqWr, errQ;
	logic [`ADDR_W-1:0] reqAddr;
	logic [`DATA_W-1:0] reqData, rdDataQ;
	logic               accept, isMap, refuse;

	// First access phase cycle.
	assign accept = (state == ST_IDLE) && i_apb.psel && i_apb.penable;
	assign isMap  = (i_apb.paddr[`ADDR_W-1 -: 2] == `MAP_PREFIX);
	// SRAM writes need a paused core.
	assign refuse = i_apb.pwrite & ~isMap & ~i_isPaused;

	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			state <= ST_IDLE;
			reqEn <= 1'b0;
			errQ  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						reqWr   <= i_apb.pwrite;
						reqAddr <= i_apb.paddr;
						reqData <= i_apb.pwdata;
						errQ    <= refuse;
						reqEn   <= ~refuse;
						state   <= refuse ? ST_DONE : ST_REQ;
					end
				end
				ST_REQ: begin
					// Mapped reads return with the grant.
					if (i_rdValid) begin
						rdDataQ <= i_rdData;
						reqEn   <= 1'b0;
						state   <= ST_DONE;
					end else if (i_grant) begin
						reqEn <= 1'b0;
						state <= reqWr ? ST_DONE : ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (i_rdValid) begin
						rdDataQ <= i_rdData;
						state   <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Response decodes straight from state.
	assign o_apb = '{prdata: rdDataQ, pready: (state == ST_DONE),
	                 pslverr: (state == ST_DONE) && errQ};
	assign o_req = '{en: reqEn, wr: reqWr, addr: reqAddr, wrData: reqData};

endmodule

`default_nettype wire

/* rtl/BootImage.sv */
`default_nettype none

`include "UProc_macros.svh"

module BootImage (
	// EEPROM pins.
	input  logic               i_sysClk,
	input  logic               i_rstN,
	input  logic               i_spiMISO,
	output logic               o_spiMOSI,
	output logic               o_spiCLK,
	output logic               o_spiCSn,

	// SRAM bus request.
	input  logic               i_grant,
	output UProcPkg::memReq_t  o_req,

	// Boot complete flag.
	output logic               o_nowBooted
);

	// FSM states.
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_CMD  = 3'd1;
	localparam logic [2:0] ST_DATA = 3'd2;
	localparam logic [2:0] ST_REQ  = 3'd3;
	localparam logic [2:0] ST_DONE = 3'd4;

	// Opcode plus 16-bit start address.
	localparam int CMD_BITS = 24;
	localparam int WCNT_W   = $clog2(`BOOT_WORDS);
	localparam int DIV_W    = $clog2(`SPI_DIV) + 1;

	logic [2:0]          state;
	logic [DIV_W-1:0]    divCnt;
	logic                spiClk, csN, reqEn, booted;
	logic [4:0]          bitCnt;
	logic [WCNT_W-1:0]   wordCnt;
	logic [CMD_BITS-1:0] cmdShift;
	logic [`DATA_W-1:0]  rxShift, wordQ;
	logic                halfTick, riseEdge, fallEdge, lastWord;

	// -------------------------------------------------------------------
	// SPI clock divider, mode 0.
	// -------------------------------------------------------------------

	// Clock only runs while shifting.
	assign halfTick = ((state == ST_CMD) || (state == ST_DATA)) &&
	                  (divCnt == DIV_W'(`SPI_DIV - 1));
	assign riseEdge = halfTick & ~spiClk;
	assign fallEdge = halfTick & spiClk;
	assign lastWord = (wordCnt == WCNT_W'(`BOOT_WORDS - 1));

	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			state   <= ST_IDLE;
			divCnt  <= '0;
			spiClk  <= 1'b0;
			csN     <= 1'b1;
			reqEn   <= 1'b0;
			booted  <= 1'b0;
			bitCnt  <= '0;
			wordCnt <= '0;
		end else begin
			if ((state == ST_CMD) || (state == ST_DATA)) begin
				divCnt <= halfTick ? '0 : divCnt + 1'b1;
			end
			if (halfTick) begin
				spiClk <= ~spiClk;
			end
			// Sample MISO on rising SCK.
			if (riseEdge) begin
				bitCnt  <= bitCnt + 1'b1;
				rxShift <= {rxShift[`DATA_W-2:0], i_spiMISO};
			end
			// Advance MOSI on falling SCK.
			if (fallEdge) begin
				cmdShift <= {cmdShift[CMD_BITS-2:0], 1'b0};
			end

			case (state)
				ST_IDLE: begin
					// Select EEPROM and load read command.
					csN      <= 1'b0;
					cmdShift <= {`EEPROM_READ, 16'h0000};
					state    <= ST_CMD;
				end
				ST_CMD: begin
					if (fallEdge && (bitCnt == 5'(CMD_BITS))) begin
						bitCnt <= '0;
						state  <= ST_DATA;
					end
				end
				ST_DATA: begin
					// Word done after its last falling edge.
					if (fallEdge && (bitCnt == 5'(`DATA_W))) begin
						bitCnt <= '0;
						wordQ  <= rxShift;
						reqEn  <= 1'b1;
						csN    <= lastWord;
						state  <= ST_REQ;
					end
				end
				ST_REQ: begin
					// Hold write until the arbiter takes it.
					if (i_grant) begin
						reqEn <= 1'b0;
						if (lastWord) begin
							booted <= 1'b1;
							state  <= ST_DONE;
						end else begin
							wordCnt <= wordCnt + 1'b1;
							state   <= ST_DATA;
						end
					end
				end
				ST_DONE: begin
					state <= ST_DONE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Pins and request.
	assign o_spiMOSI   = cmdShift[CMD_BITS-1];
	assign o_spiCLK    = spiClk;
	assign o_spiCSn    = csN;
	assign o_nowBooted = booted;
	assign o_req       = '{en: reqEn, wr: 1'b1, addr: `ADDR_W'(wordCnt), wrData: wordQ};

endmodule

`default_nettype wire

/* rtl/UProcPkg.sv */
`default_nettype none

`include "UProc_macros.svh"

package UProcPkg;

	// One request onto the shared SRAM bus.
	typedef struct packed {
		logic               en;
		logic               wr;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wrData;
	} memReq_t;

	// APB requester side.
	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [`ADDR_W-1:0] paddr;
		logic [`DATA_W-1:0] pwdata;
	} apbReq_t;

	// APB completer side.
	typedef struct packed {
		logic [`DATA_W-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apbRsp_t;

	// CCTRL bit fields.
	typedef struct packed {
		logic       pause;
		logic [9:0] rsvd;
		logic       intEn;
		logic [3:0] intCode;
	} cctrlFields_t;

	// CCTRL as raw bus word or as decoded fields.
	typedef union packed {
		logic [`DATA_W-1:0] raw;
		cctrlFields_t       f;
	} cctrlWord_u;

endpackage

`default_nettype wire

/* rtl/UProc_macros.svh */
`ifndef UPROC_MACROS_SVH
`define UPROC_MACROS_SVH

// Bus widths.
`define DATA_W 16
`define ADDR_W 16

// Number of image words copied out of the EEPROM at boot.
`define BOOT_WORDS 8

// System clocks per SPI clock half period.
`define SPI_DIV 2

// Address bits 15:14 that select the mapped registers.
`define MAP_PREFIX 2'b11

// EEPROM read opcode.
`define EEPROM_READ 8'h03

`endif
